// File: design/msx_config.svh
// Build constants for the tape path and the DDR3 buffer port
// DDR3_CREDITS must fit the 3-bit credit counter
// CAS_IOCTL_INDEX is matched against the low 6 bits of the download index
`ifndef MSX_CONFIG_SVH
`define MSX_CONFIG_SVH

// Address widths
`define DDR3_ADDR_W     28
`define IOCTL_ADDR_W    27

// CAS file location in the download stream and in DDR3
`define CAS_IOCTL_INDEX 6'd5
`define CAS_BASE_ADDR   28'h1600000

// Reads allowed in flight on the DDR3 port
`define DDR3_CREDITS    4

// ce_5m39 pulses per tape bit
`define CAS_BIT_CE      4

`endif

// File: design/msx_pkg.sv
// Shared types for the tape path, the DDR3 port and the video crop
// Vector widths come from the config header
package msx_pkg;

`include "msx_config.svh"

   // ====================
   // Vector types
   // ====================
   typedef logic [`DDR3_ADDR_W-1:0]  ddr3_addr_t;
   typedef logic [`IOCTL_ADDR_W-1:0] ioctl_addr_t;
   typedef logic [7:0]               byte_t;
   typedef logic [11:0]              hdmi_dim_t;
   typedef logic [11:0]              crop_t;
   typedef logic [11:0]              aspect_t;
   typedef logic [1:0]               ar_sel_t;
   typedef logic [2:0]               credit_t;

   // ====================
   // State machines
   // ====================
   typedef enum logic [1:0] {
      CAS_IDLE,
      CAS_FETCH,
      CAS_PLAY,
      CAS_END
   } cas_state_t;

   typedef enum logic [1:0] {
      ARB_CAS,
      ARB_DRAIN,
      ARB_DL
   } arb_owner_t;

   typedef enum logic {
      CAS_SRC_FILE,
      CAS_SRC_ADC
   } cas_src_t;

endpackage

// File: design/ddr3_arbiter.sv
// DDR3 read port shared by the download engine and the cassette player
// The download engine must drop dl_request only after its own reads came back
// A read strobe seen without a credit is not issued and must be retried
// The player gets at most one read in flight
`timescale 1ns/10ps
`include "msx_config.svh"

module ddr3_arbiter (
   input  logic                clk21m,
   input  logic                rst,
   input  logic                dl_request,
   input  logic                dl_rd,
   input  msx_pkg::ddr3_addr_t dl_addr,
   input  logic                cas_rd,
   input  msx_pkg::ddr3_addr_t cas_addr,
   input  logic                ddr3_ready,
   output logic                dl_grant,
   output logic                dl_ready,
   output logic                cas_ready,
   output logic                ddr3_rd,
   output msx_pkg::ddr3_addr_t ddr3_addr
);
   import msx_pkg::*;

   localparam credit_t CREDITS_MAX = credit_t'(`DDR3_CREDITS);

   arb_owner_t owner;
   credit_t    credits;
   logic       have_credit;
   logic       cas_busy;

   assign have_credit = (credits != '0);

   // Read strobe and address follow the owner
   always_comb begin
      case (owner)
         ARB_DL:  ddr3_rd = dl_rd & have_credit;
         ARB_CAS: ddr3_rd = cas_rd & have_credit & ~cas_busy;
         default: ddr3_rd = 1'b0;
      endcase
   end

   assign ddr3_addr = (owner == ARB_DL) ? dl_addr : cas_addr;
   assign dl_grant  = (owner == ARB_DL);
   assign dl_ready  = ddr3_ready & (owner == ARB_DL);
   assign cas_ready = ddr3_ready & (owner != ARB_DL);

   // ====================
   // Ownership
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         owner <= ARB_CAS;
      end else begin
         case (owner)
            ARB_CAS: begin
               if (dl_request) owner <= ARB_DRAIN;
            end
            ARB_DRAIN: begin
               // Player reads still in flight must come home first
               if (!dl_request) owner <= ARB_CAS;
               else if (credits == CREDITS_MAX) owner <= ARB_DL;
            end
            ARB_DL: begin
               if (!dl_request) owner <= ARB_CAS;
            end
            default: owner <= ARB_CAS;
         endcase
      end
   end

   // ====================
   // Credits
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         credits  <= CREDITS_MAX;
         cas_busy <= 1'b0;
      end else begin
         case ({ddr3_rd, ddr3_ready})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         // Held cas_rd turns into a single read
         if (cas_ready) cas_busy <= 1'b0;
         else if (owner == ARB_CAS && ddr3_rd) cas_busy <= 1'b1;
      end
   end

endmodule

// File: design/cas_player.sv
// CAS file player reading the downloaded image back from DDR3
// Bits leave MSB first, each held for CAS_BIT_CE ce_5m39 pulses
// motor is active low, and a running download acts as a rewind
// cas_rd is held until cas_ready, one byte in flight at a time
`timescale 1ns/10ps
`include "msx_config.svh"

module cas_player (
   input  logic                 clk21m,
   input  logic                 rst,
   input  logic                 ce_5m39,
   input  logic                 ioctl_download,
   input  logic [15:0]          ioctl_index,
   input  msx_pkg::ioctl_addr_t ioctl_addr,
   input  logic                 cas_rewind,
   input  logic                 motor,
   input  msx_pkg::cas_src_t    cas_src,
   input  logic                 tape_adc,
   input  logic                 tape_adc_act,
   input  logic                 cas_ready,
   input  msx_pkg::byte_t       ddr3_dout,
   output logic                 cas_rd,
   output msx_pkg::ddr3_addr_t  cas_addr,
   output logic                 cas_out,
   output logic                 cas_active
);
   import msx_pkg::*;

   localparam int              CE_W    = $clog2(`CAS_BIT_CE + 1);
   localparam logic [CE_W-1:0] CE_LAST = CE_W'(`CAS_BIT_CE - 1);

   cas_state_t      state;
   logic            is_cas;
   logic            is_cas_q;
   logic            loaded;
   logic            restart;
   ddr3_addr_t      dl_len;
   ddr3_addr_t      cas_len;
   ddr3_addr_t      rd_ptr;
   logic            rd_req;
   logic            rd_drop;
   logic            pf_valid;
   byte_t           pf_byte;
   byte_t           sh_byte;
   logic [2:0]      sh_cnt;
   logic [CE_W-1:0] ce_cnt;
   logic            bit_end;
   logic            more_data;
   logic            load_sh;
   logic            shift_sh;
   logic            file_bit;

   assign is_cas    = ioctl_download & (ioctl_index[5:0] == `CAS_IOCTL_INDEX);
   assign restart   = cas_rewind | is_cas;
   assign dl_len    = ddr3_addr_t'(ioctl_addr) + 1'b1;
   assign more_data = rd_req | (rd_ptr < cas_len);
   assign bit_end   = ce_5m39 & ~motor & (ce_cnt == CE_LAST);
   assign load_sh   = pf_valid & ~restart & ((state == CAS_FETCH) |
                      ((state == CAS_PLAY) & bit_end & (sh_cnt == 3'd0)));
   assign shift_sh  = (state == CAS_PLAY) & bit_end & (sh_cnt != 3'd0);

   assign cas_rd    = rd_req;
   assign cas_addr  = `CAS_BASE_ADDR + rd_ptr;
   assign file_bit  = cas_active & sh_byte[7];
   assign cas_out   = (cas_src == CAS_SRC_FILE) ? file_bit : (tape_adc & tape_adc_act);

   // ====================
   // Download tracking
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         is_cas_q <= 1'b0;
         loaded   <= 1'b0;
         cas_len  <= '0;
      end else begin
         is_cas_q <= is_cas;
         if (is_cas && !is_cas_q) begin
            loaded  <= 1'b0;
            cas_len <= dl_len;
         end else if (is_cas && dl_len > cas_len) begin
            cas_len <= dl_len;
         end
         if (!is_cas && is_cas_q) loaded <= 1'b1;
      end
   end

   // Prefetch byte and shift register
   always_ff @(posedge clk21m) begin
      if (cas_ready && !rd_drop) pf_byte <= ddr3_dout;
      if (load_sh) sh_byte <= pf_byte;
      else if (shift_sh) sh_byte <= {sh_byte[6:0], 1'b0};
   end

   // ====================
   // Fetch and playback
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         state      <= CAS_IDLE;
         rd_req     <= 1'b0;
         rd_drop    <= 1'b0;
         rd_ptr     <= '0;
         pf_valid   <= 1'b0;
         sh_cnt     <= '0;
         ce_cnt     <= '0;
         cas_active <= 1'b0;
      end else begin
         // A read cut by a rewind still returns and is thrown away
         if (rd_req) begin
            if (cas_ready) begin
               rd_req  <= 1'b0;
               rd_drop <= 1'b0;
               if (!rd_drop && !restart) begin
                  pf_valid <= 1'b1;
                  rd_ptr   <= rd_ptr + 1'b1;
               end
            end else if (restart) begin
               rd_drop <= 1'b1;
            end
         end else if (loaded && !restart && !pf_valid && rd_ptr < cas_len) begin
            rd_req <= 1'b1;
         end
         if (load_sh) pf_valid <= 1'b0;

         case (state)
            CAS_IDLE: begin
               if (loaded && !restart) state <= CAS_FETCH;
            end
            CAS_FETCH: begin
               // Last level stays on the tape while waiting
               if (load_sh) begin
                  state      <= CAS_PLAY;
                  sh_cnt     <= 3'd7;
                  ce_cnt     <= '0;
                  cas_active <= 1'b1;
               end else if (!more_data) begin
                  state      <= CAS_END;
                  cas_active <= 1'b0;
               end
            end
            CAS_PLAY: begin
               if (ce_5m39 && !motor) ce_cnt <= bit_end ? '0 : ce_cnt + 1'b1;
               if (bit_end) begin
                  if (sh_cnt != 3'd0) begin
                     sh_cnt <= sh_cnt - 1'b1;
                  end else if (load_sh) begin
                     sh_cnt <= 3'd7;
                  end else if (more_data) begin
                     state <= CAS_FETCH;
                  end else begin
                     state      <= CAS_END;
                     cas_active <= 1'b0;
                  end
               end
            end
            default: begin
               // End of tape until rewind or a new file
               cas_active <= 1'b0;
            end
         endcase

         if (restart) begin
            state      <= CAS_IDLE;
            cas_active <= 1'b0;
            rd_ptr     <= '0;
            pf_valid   <= 1'b0;
         end
      end
   end

endmodule

// File: design/video_crop.sv
// Crop size and aspect values for the HDMI output
// All outputs are registered, one clock behind their inputs
// Crop applies only without the scandoubler
`timescale 1ns/10ps

module video_crop (
   input  logic               clk21m,
   input  logic               rst,
   input  msx_pkg::hdmi_dim_t hdmi_width,
   input  msx_pkg::hdmi_dim_t hdmi_height,
   input  logic               scandoubler,
   input  logic               vcrop_en,
   input  msx_pkg::ar_sel_t   ar,
   output msx_pkg::crop_t     crop_size,
   output msx_pkg::aspect_t   arx,
   output msx_pkg::aspect_t   ary
);
   import msx_pkg::*;

   logic [12:0] height_1p5;
   logic        wide_shape;
   logic        big_4x3;
   crop_t       vcrop;
   logic        wide;
   aspect_t     arx_next;
   aspect_t     ary_next;

   // Width at least 1.5 times height, kept in 13 bits
   assign height_1p5 = {1'b0, hdmi_height} + {2'b00, hdmi_height[11:1]};
   assign wide_shape = ({1'b0, hdmi_width} >= height_1p5);
   assign big_4x3    = (hdmi_width >= 12'd1440);

   always_comb begin
      vcrop = '0;
      wide  = 1'b0;
      if (!scandoubler) begin
         if (wide_shape) begin
            case (hdmi_height)
               12'd480, 12'd720, 12'd1200: vcrop = 12'd240;
               12'd600, 12'd800: begin
                  vcrop = 12'd200;
                  wide  = vcrop_en;
               end
               12'd768:  vcrop = 12'd256;
               12'd1080: vcrop = 12'd216;
               default:  vcrop = '0;
            endcase
         end else if (big_4x3) begin
            // 4:3 modes too tall for the first test
            case (hdmi_height)
               12'd1440: vcrop = 12'd240;
               12'd1536: vcrop = 12'd256;
               default:  vcrop = '0;
            endcase
         end
      end
   end

   always_comb begin
      case (ar)
         2'd0: begin
            arx_next = wide ? 12'd340 : 12'd400;
            ary_next = 12'd300;
         end
         2'd1: begin
            arx_next = '0;
            ary_next = '0;
         end
         default: begin
            // Custom aspect codes for the scaler
            arx_next = aspect_t'(ar) - 1'b1;
            ary_next = '0;
         end
      endcase
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         crop_size <= '0;
         arx       <= '0;
         ary       <= '0;
      end else begin
         crop_size <= vcrop_en ? vcrop : '0;
         arx       <= arx_next;
         ary       <= ary_next;
      end
   end

endmodule

// File: design/msx_tape_top.sv
// Cassette path, shared DDR3 read port and HDMI crop selection
// The download engine and the DDR3 buffer sit outside this block
// Read data goes to both requesters unchanged
`timescale 1ns/10ps

module msx_tape_top (
   input  logic                 clk21m,
   input  logic                 rst,
   input  logic                 ce_5m39,
   input  logic                 ioctl_download,
   input  logic [15:0]          ioctl_index,
   input  msx_pkg::ioctl_addr_t ioctl_addr,
   input  logic                 cas_rewind,
   input  logic                 motor,
   input  msx_pkg::cas_src_t    cas_src,
   input  logic                 tape_adc,
   input  logic                 tape_adc_act,
   input  logic                 dl_request,
   input  logic                 dl_rd,
   input  msx_pkg::ddr3_addr_t  dl_addr,
   output logic                 dl_grant,
   output logic                 dl_ready,
   output logic                 ddr3_rd,
   output msx_pkg::ddr3_addr_t  ddr3_addr,
   input  msx_pkg::byte_t       ddr3_dout,
   input  logic                 ddr3_ready,
   output msx_pkg::byte_t       dl_dout,
   output logic                 cas_out,
   output logic                 cas_active,
   input  msx_pkg::hdmi_dim_t   hdmi_width,
   input  msx_pkg::hdmi_dim_t   hdmi_height,
   input  logic                 scandoubler,
   input  logic                 vcrop_en,
   input  msx_pkg::ar_sel_t     ar,
   output msx_pkg::crop_t       crop_size,
   output msx_pkg::aspect_t     arx,
   output msx_pkg::aspect_t     ary
);

   // Player side of the arbiter
   logic                cas_rd;
   msx_pkg::ddr3_addr_t cas_addr;
   logic                cas_ready;

   assign dl_dout = ddr3_dout;

   ddr3_arbiter arbiter_i (
      .clk21m     (clk21m),
      .rst        (rst),
      .dl_request (dl_request),
      .dl_rd      (dl_rd),
      .dl_addr    (dl_addr),
      .cas_rd     (cas_rd),
      .cas_addr   (cas_addr),
      .ddr3_ready (ddr3_ready),
      .dl_grant   (dl_grant),
      .dl_ready   (dl_ready),
      .cas_ready  (cas_ready),
      .ddr3_rd    (ddr3_rd),
      .ddr3_addr  (ddr3_addr)
   );

   cas_player player_i (
      .clk21m         (clk21m),
      .rst            (rst),
      .ce_5m39        (ce_5m39),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .cas_rewind     (cas_rewind),
      .motor          (motor),
      .cas_src        (cas_src),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .cas_ready      (cas_ready),
      .ddr3_dout      (ddr3_dout),
      .cas_rd         (cas_rd),
      .cas_addr       (cas_addr),
      .cas_out        (cas_out),
      .cas_active     (cas_active)
   );

   video_crop crop_i (
      .clk21m      (clk21m),
      .rst         (rst),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .scandoubler (scandoubler),
      .vcrop_en    (vcrop_en),
      .ar          (ar),
      .crop_size   (crop_size),
      .arx         (arx),
      .ary         (ary)
   );

endmodule

// File: sim/ddr3_model.sv
// Behavioral DDR3 read buffer, read port only
// Every read is answered RD_LATENCY clocks later, in request order
// A MEM_BYTES window at CAS_BASE_ADDR is preloadable, other addresses return a fill pattern
// credit_err sticks once more than DDR3_CREDITS reads were in flight
`timescale 1ns/10ps
`include "msx_config.svh"

module ddr3_model #(
   parameter int RD_LATENCY = 3,
   parameter int MEM_BYTES  = 64
) (
   input  logic                clk21m,
   input  logic                rst,
   input  logic                ddr3_rd,
   input  msx_pkg::ddr3_addr_t ddr3_addr,
   output msx_pkg::byte_t      ddr3_dout,
   output logic                ddr3_ready,
   output logic                credit_err
);
   import msx_pkg::*;

   byte_t mem      [0:MEM_BYTES-1];
   logic  vld_pipe [0:RD_LATENCY-1];
   byte_t dat_pipe [0:RD_LATENCY-1];
   int    outstanding;
   int    next_outstanding;

   // Pattern folds all address bits into one byte
   function automatic byte_t fill_byte(input ddr3_addr_t addr);
      return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {4'h0, addr[27:24]};
   endfunction

   function automatic byte_t read_byte(input ddr3_addr_t addr);
      ddr3_addr_t offs;
      offs = addr - `CAS_BASE_ADDR;
      if (offs < ddr3_addr_t'(MEM_BYTES)) read_byte = mem[int'(offs)];
      else read_byte = fill_byte(addr);
   endfunction

   initial begin
      outstanding = 0;
      for (int i = 0; i < MEM_BYTES; i++) begin
         mem[i] = fill_byte(`CAS_BASE_ADDR + ddr3_addr_t'(i));
      end
   end

   assign next_outstanding = outstanding + int'(ddr3_rd) - int'(ddr3_ready);
   assign ddr3_ready       = rst ? 1'b0 : vld_pipe[RD_LATENCY-1];
   assign ddr3_dout        = rst ? '0 : dat_pipe[RD_LATENCY-1];

   // ====================
   // Read latency pipe
   // ====================
   always @(posedge clk21m) begin
      if (rst) begin
         for (int i = 0; i < RD_LATENCY; i++) begin
            vld_pipe[i] <= 1'b0;
            dat_pipe[i] <= '0;
         end
         outstanding <= 0;
         credit_err  <= 1'b0;
      end else begin
         vld_pipe[0] <= ddr3_rd;
         dat_pipe[0] <= read_byte(ddr3_addr);
         for (int i = 1; i < RD_LATENCY; i++) begin
            vld_pipe[i] <= vld_pipe[i-1];
            dat_pipe[i] <= dat_pipe[i-1];
         end
         outstanding <= next_outstanding;
         if (next_outstanding > `DDR3_CREDITS) credit_err <= 1'b1;
      end
   end

endmodule

// File: sim/tb_msx_tape.sv
// Directed testbench for the tape path, the shared DDR3 port and the video crop
// ce_5m39 pulses every CE_SPACING clocks, the DDR3 model answers 3 clocks after a read
// Inputs change on the falling edge, every wait gives up after its own timeout
`timescale 1ns/10ps
`include "msx_config.svh"

module tb_msx_tape;
   import msx_pkg::*;

   localparam int         CE_SPACING = 4;
   localparam int         CE_WAIT    = 2 * CE_SPACING;
   localparam int         WAIT_CLKS  = 200;
   localparam int         CAS_LEN    = 16;
   localparam int         DL_OFFS    = 48;
   localparam int         DL_READS   = 8;
   localparam ddr3_addr_t CAS_BASE   = `CAS_BASE_ADDR;

   logic        clk21m;
   logic        rst;
   logic        ce_5m39 = 1'b0;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   ioctl_addr_t ioctl_addr;
   logic        cas_rewind;
   logic        motor;
   cas_src_t    cas_src;
   logic        tape_adc;
   logic        tape_adc_act;
   logic        dl_request;
   logic        dl_rd;
   ddr3_addr_t  dl_addr;
   logic        dl_grant;
   logic        dl_ready;
   logic        ddr3_rd;
   ddr3_addr_t  ddr3_addr;
   byte_t       ddr3_dout;
   logic        ddr3_ready;
   byte_t       dl_dout;
   logic        cas_out;
   logic        cas_active;
   hdmi_dim_t   hdmi_width;
   hdmi_dim_t   hdmi_height;
   logic        scandoubler;
   logic        vcrop_en;
   ar_sel_t     ar;
   crop_t       crop_size;
   aspect_t     arx;
   aspect_t     ary;
   logic        credit_err;

   integer seed;
   byte_t  cas_bytes [0:CAS_LEN-1];
   string  cur_test;
   int     test_errs;
   int     err_count  = 0;
   int     test_count = 0;
   int     fail_count = 0;
   int     ce_phase   = 0;

   msx_tape_top dut_i (.*);

   ddr3_model model_i (
      .clk21m     (clk21m),
      .rst        (rst),
      .ddr3_rd    (ddr3_rd),
      .ddr3_addr  (ddr3_addr),
      .ddr3_dout  (ddr3_dout),
      .ddr3_ready (ddr3_ready),
      .credit_err (credit_err)
   );

   initial clk21m = 1'b0;
   always #5 clk21m = ~clk21m;

   // Pixel clock enable
   always @(negedge clk21m) begin
      if (rst) begin
         ce_phase <= 0;
         ce_5m39  <= 1'b0;
      end else begin
         ce_phase <= (ce_phase == CE_SPACING - 1) ? 0 : ce_phase + 1;
         ce_5m39  <= (ce_phase == CE_SPACING - 1);
      end
   end

   // ====================
   // Reporting
   // ====================
   task automatic begin_test(input string name);
      cur_test   = name;
      test_errs  = 0;
      test_count = test_count + 1;
   endtask

   task automatic end_test();
      if (test_errs == 0) begin
         $display("Test %s: ok", cur_test);
      end else begin
         $display("Test %s: failed with %0d errors", cur_test, test_errs);
         fail_count = fail_count + 1;
      end
   endtask

   task automatic note_error();
      test_errs = test_errs + 1;
      err_count = err_count + 1;
   endtask

   task automatic abort_timeout(input string what);
      $display("Timeout in test %s while waiting for %s", cur_test, what);
      $display("*** FAILED ***");
      $finish;
   endtask

   task automatic check_byte(input string what, input byte_t exp, input byte_t act);
      if (act !== exp) begin
         $display("Error: %s %s expected 0x%02h actual 0x%02h", cur_test, what, exp, act);
         note_error();
      end
   endtask

   task automatic check_crop(input string what, input crop_t exp, input crop_t act);
      if (act !== exp) begin
         $display("Error: %s %s expected %0d actual %0d", cur_test, what, exp, act);
         note_error();
      end
   endtask

   task automatic check_aspect(input string what, input aspect_t exp, input aspect_t act);
      if (act !== exp) begin
         $display("Error: %s %s expected %0d actual %0d", cur_test, what, exp, act);
         note_error();
      end
   endtask

   task automatic check_bit(input string what, input bit exp, input logic act);
      if (act !== exp) begin
         $display("Error: %s %s expected %0b actual %0b", cur_test, what, exp, act);
         note_error();
      end
   endtask

   // ====================
   // Waits
   // ====================
   task automatic wait_grant(input logic level);
      int n;
      n = 0;
      @(negedge clk21m);
      while (dl_grant !== level) begin
         if (n == WAIT_CLKS) abort_timeout("dl_grant");
         @(negedge clk21m);
         n++;
      end
   endtask

   task automatic wait_cas_active(input logic level);
      int n;
      n = 0;
      @(negedge clk21m);
      while (cas_active !== level) begin
         if (n == WAIT_CLKS) abort_timeout("cas_active");
         @(negedge clk21m);
         n++;
      end
   endtask

   // Returns on the rising edge that carries the next enable
   task automatic wait_ce();
      int n;
      n = 0;
      @(posedge clk21m);
      while (ce_5m39 !== 1'b1) begin
         if (n == CE_WAIT) abort_timeout("ce_5m39");
         @(posedge clk21m);
         n++;
      end
   endtask

   // ====================
   // Stimulus helpers
   // ====================
   task automatic set_video(input hdmi_dim_t w, input hdmi_dim_t h, input logic sd,
                            input logic vc, input ar_sel_t a);
      @(negedge clk21m);
      hdmi_width  = w;
      hdmi_height = h;
      scandoubler = sd;
      vcrop_en    = vc;
      ar          = a;
      repeat (2) @(negedge clk21m);
   endtask

   task automatic check_video(input string what, input crop_t c, input aspect_t x,
                              input aspect_t y);
      check_crop({what, " crop_size"}, c, crop_size);
      check_aspect({what, " arx"}, x, arx);
      check_aspect({what, " ary"}, y, ary);
   endtask

   task automatic issue_dl_reads(input int first, input int count);
      for (int i = first; i < first + count; i++) begin
         dl_rd   = 1'b1;
         dl_addr = CAS_BASE + ddr3_addr_t'(DL_OFFS + i);
         @(negedge clk21m);
      end
      dl_rd = 1'b0;
   endtask

   task automatic collect_dl_reads(input int first, input int count);
      int n;
      for (int i = first; i < first + count; i++) begin
         n = 0;
         @(negedge clk21m);
         while (dl_ready !== 1'b1) begin
            if (n == WAIT_CLKS) abort_timeout("dl_ready");
            @(negedge clk21m);
            n++;
         end
         check_byte($sformatf("read %0d", i), model_i.mem[DL_OFFS + i], dl_dout);
      end
   endtask

   task automatic load_cas_file();
      @(negedge clk21m);
      ioctl_index    = {10'd0, `CAS_IOCTL_INDEX};
      ioctl_download = 1'b1;
      for (int i = 0; i < CAS_LEN; i++) begin
         ioctl_addr = ioctl_addr_t'(i);
         @(negedge clk21m);
      end
      ioctl_download = 1'b0;
      motor          = 1'b0;
   endtask

   // Samples each bit after half of its enables, MSB first
   task automatic check_stream(input int first, input int count);
      for (int i = first; i < first + count; i++) begin
         for (int b = 7; b >= 0; b--) begin
            repeat (`CAS_BIT_CE / 2) wait_ce();
            @(negedge clk21m);
            check_bit($sformatf("byte %0d bit %0d", i, b), cas_bytes[i][b], cas_out);
            repeat (`CAS_BIT_CE - `CAS_BIT_CE / 2) wait_ce();
         end
      end
   endtask

   // ====================
   // Tests
   // ====================
   task automatic test_crop_aspect();
      begin_test("crop_aspect");
      set_video(12'd1920, 12'd1080, 1'b0, 1'b1, 2'd0);
      check_video("1080p", 12'd216, 12'd400, 12'd300);
      set_video(12'd1280, 12'd800, 1'b0, 1'b1, 2'd0);
      check_video("800p wide", 12'd200, 12'd340, 12'd300);
      set_video(12'd1920, 12'd1080, 1'b1, 1'b1, 2'd0);
      check_video("scandoubler", 12'd0, 12'd400, 12'd300);
      set_video(12'd1920, 12'd1080, 1'b0, 1'b1, 2'd1);
      check_video("full screen", 12'd216, 12'd0, 12'd0);
      set_video(12'd1920, 12'd1080, 1'b0, 1'b1, 2'd2);
      check_video("custom aspect", 12'd216, 12'd1, 12'd0);
      end_test();
   endtask

   task automatic test_download_reads();
      begin_test("download_reads");
      @(negedge clk21m);
      motor      = 1'b1;
      dl_request = 1'b1;
      wait_grant(1'b1);
      for (int first = 0; first < DL_READS; first += `DDR3_CREDITS) begin
         fork
            issue_dl_reads(first, `DDR3_CREDITS);
            collect_dl_reads(first, `DDR3_CREDITS);
         join
      end
      @(negedge clk21m);
      dl_request = 1'b0;
      wait_grant(1'b0);
      end_test();
   endtask

   task automatic test_cas_stream();
      begin_test("cas_stream");
      load_cas_file();
      wait_cas_active(1'b1);
      check_stream(0, 3);
      end_test();
   endtask

   task automatic test_rewind_eof();
      begin_test("rewind_eof");
      @(negedge clk21m);
      cas_rewind = 1'b1;
      @(negedge clk21m);
      cas_rewind = 1'b0;
      check_bit("cas_active after rewind", 1'b0, cas_active);
      wait_cas_active(1'b1);
      check_stream(0, CAS_LEN);
      wait_cas_active(1'b0);
      check_bit("cas_out at end of file", 1'b0, cas_out);
      end_test();
   endtask

   task automatic test_adc_source();
      begin_test("adc_source");
      for (int i = 0; i < 4; i++) begin
         @(negedge clk21m);
         cas_src      = CAS_SRC_ADC;
         tape_adc     = i[0];
         tape_adc_act = i[1];
         @(posedge clk21m);
         check_bit($sformatf("adc %0d act %0d", i[0], i[1]), i[0] & i[1], cas_out);
      end
      end_test();
   endtask

   task automatic test_credit_limit();
      begin_test("credit_limit");
      check_bit("reads beyond credit", 1'b0, credit_err);
      end_test();
   endtask

   // ====================
   // Main sequence
   // ====================
   initial begin
      seed           = 32'h7ed3;
      rst            = 1'b1;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      cas_rewind     = 1'b0;
      motor          = 1'b1;
      cas_src        = CAS_SRC_FILE;
      tape_adc       = 1'b0;
      tape_adc_act   = 1'b0;
      dl_request     = 1'b0;
      dl_rd          = 1'b0;
      dl_addr        = '0;
      hdmi_width     = '0;
      hdmi_height    = '0;
      scandoubler    = 1'b0;
      vcrop_en       = 1'b0;
      ar             = '0;
      repeat (8) @(posedge clk21m);
      @(negedge clk21m);
      rst = 1'b0;
      // CAS image in the buffer, kept here for the expected bits
      for (int i = 0; i < CAS_LEN; i++) begin
         cas_bytes[i]   = byte_t'($random(seed));
         model_i.mem[i] = cas_bytes[i];
      end
      test_crop_aspect();
      test_download_reads();
      test_cas_stream();
      test_rewind_eof();
      test_adc_source();
      test_credit_limit();
      $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_count,
               err_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+design
design/msx_pkg.sv
design/ddr3_arbiter.sv
design/cas_player.sv
design/video_crop.sv
design/msx_tape_top.sv
sim/ddr3_model.sv
sim/tb_msx_tape.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_msx_tape
FILELIST  = list.f
SIM_BIN   = obj_dir/V$(TOP)
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf obj_dir
